/* hdl/mem_bridge_config.svh */
`ifndef MEM_BRIDGE_CONFIG_SVH
`define MEM_BRIDGE_CONFIG_SVH

// entries in each strobe FIFO
`define MB_FIFO_DEPTH 4

// lines held by the store, power of two
`define MB_LINE_COUNT 64

// bytes per line, one select bit each
`define MB_LINE_BYTES 16

`endif

/* hdl/mem_bridge_pkg.sv */
`include "mem_bridge_config.svh"

package mem_bridge_pkg;

	// processor side
	typedef logic [15:0] word_t;
	typedef logic [1:0] wmask_t;

	// line side
	typedef logic [`MB_LINE_BYTES*8-1:0] line_t;
	typedef logic [`MB_LINE_BYTES-1:0] sel_t;

	typedef struct packed {
		logic we;
		word_t adr;
		sel_t sel;
		line_t dat;
	} line_req_t;

	// lane echoes address bits 3 to 1 of the request
	typedef struct packed {
		line_t dat;
		logic [2:0] lane;
	} line_rsp_t;

endpackage : mem_bridge_pkg

/* hdl/strobe_fifo.sv */
`timescale 1ns/1ps

`include "mem_bridge_config.svh"

module strobe_fifo #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst_n,
	input logic push,
	input payload_t push_data,
	output logic full,
	input logic pop,
	output payload_t head,
	output logic empty
);

	localparam int unsigned DEPTH = `MB_FIFO_DEPTH;
	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(DEPTH + 1);

	payload_t entries [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	// strobes outside the legal range are dropped
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	assign head = entries[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			entries[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule : strobe_fifo

/* hdl/word_lane_adapter.sv */
`timescale 1ns/1ps

`include "mem_bridge_config.svh"

module word_lane_adapter (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input mem_bridge_pkg::wmask_t mem_byte_enable,
	input mem_bridge_pkg::word_t mem_address,
	input mem_bridge_pkg::word_t mem_wdata,
	output logic mem_resp,
	output mem_bridge_pkg::word_t mem_rdata,
	output logic req_push,
	output mem_bridge_pkg::line_req_t req_data,
	input logic req_full,
	output logic rsp_pop,
	input mem_bridge_pkg::line_rsp_t rsp_data,
	input logic rsp_empty
);

	logic outstanding;
	logic req_level;
	logic [2:0] lane;
	mem_bridge_pkg::word_t masked_wdata;
	mem_bridge_pkg::sel_t lane_sel;
	mem_bridge_pkg::line_t lane_dat;

	assign req_level = mem_read | mem_write;

	// word lane within the line, bit 0 ignored
	assign lane = mem_address[3:1];

	// drop disabled bytes before placement
	always_comb begin
		masked_wdata[7:0] = mem_byte_enable[0] ? mem_wdata[7:0] : 8'h00;
		masked_wdata[15:8] = mem_byte_enable[1] ? mem_wdata[15:8] : 8'h00;
	end

	// two select bits and sixteen data bits per lane
	assign lane_sel = mem_bridge_pkg::sel_t'(mem_byte_enable) << {lane, 1'b0};
	assign lane_dat = mem_bridge_pkg::line_t'(masked_wdata) << {lane, 4'b0000};

	always_comb begin
		req_data.we = mem_write;
		req_data.adr = mem_address;
		req_data.sel = lane_sel;
		req_data.dat = lane_dat;
	end

	// one push per held request level
	assign req_push = req_level & ~outstanding & ~req_full;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			outstanding <= 1'b0;
		end else if (req_push) begin
			outstanding <= 1'b1;
		end else if (rsp_pop) begin
			outstanding <= 1'b0;
		end
	end

	// response head is consumed in the cycle it shows up
	assign rsp_pop = ~rsp_empty;
	assign mem_resp = rsp_pop;

	// full word at the echoed lane, whatever the enable was
	assign mem_rdata = rsp_data.dat[{rsp_data.lane, 4'b0000} +: 16];

endmodule : word_lane_adapter

/* hdl/line_store.sv */
`timescale 1ns/1ps

`include "mem_bridge_config.svh"

module line_store (
	input logic clk,
	input logic rst_n,
	output logic req_pop,
	input mem_bridge_pkg::line_req_t req_head,
	input logic req_empty,
	output logic rsp_push,
	output mem_bridge_pkg::line_rsp_t rsp_data,
	input logic rsp_full
);

	localparam int unsigned IDX_W = (`MB_LINE_COUNT > 1) ? $clog2(`MB_LINE_COUNT) : 1;

	mem_bridge_pkg::line_t lines [`MB_LINE_COUNT];
	logic [`MB_LINE_COUNT-1:0] line_valid;
	logic [IDX_W-1:0] line_idx;
	mem_bridge_pkg::line_t stored_line;
	mem_bridge_pkg::line_t merged_line;
	logic do_write;

	// line index wraps at the line count
	assign line_idx = IDX_W'(req_head.adr[15:4] % `MB_LINE_COUNT);

	// unwritten lines look like zero
	assign stored_line = line_valid[line_idx] ? lines[line_idx] : '0;

	always_comb begin
		merged_line = stored_line;
		for (int b = 0; b < `MB_LINE_BYTES; b++) begin
			if (req_head.sel[b]) begin
				merged_line[b*8 +: 8] = req_head.dat[b*8 +: 8];
			end
		end
	end

	// no pop while the previous response is still going out
	assign req_pop = ~req_empty & ~rsp_full & ~rsp_push;

	assign do_write = req_pop & req_head.we;

	always_ff @(posedge clk) begin
		if (do_write) begin
			lines[line_idx] <= merged_line;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_valid <= '0;
		end else if (do_write) begin
			line_valid[line_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_push <= 1'b0;
		end else begin
			rsp_push <= req_pop;
		end
	end

	// result line for writes, stored line for reads
	always_ff @(posedge clk) begin
		if (req_pop) begin
			rsp_data.dat <= req_head.we ? merged_line : stored_line;
			rsp_data.lane <= req_head.adr[3:1];
		end
	end

endmodule : line_store

/* hdl/mem_bridge_top.sv */
`timescale 1ns/1ps

module mem_bridge_top (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input mem_bridge_pkg::wmask_t mem_byte_enable,
	input mem_bridge_pkg::word_t mem_address,
	input mem_bridge_pkg::word_t mem_wdata,
	output logic mem_resp,
	output mem_bridge_pkg::word_t mem_rdata
);

	// request path
	logic req_push;
	mem_bridge_pkg::line_req_t req_data;
	logic req_full;
	logic req_pop;
	mem_bridge_pkg::line_req_t req_head;
	logic req_empty;

	// response path
	logic rsp_push;
	mem_bridge_pkg::line_rsp_t rsp_data;
	logic rsp_full;
	logic rsp_pop;
	mem_bridge_pkg::line_rsp_t rsp_head;
	logic rsp_empty;

	word_lane_adapter u_adapter (
		.clk,
		.rst_n,
		.mem_read,
		.mem_write,
		.mem_byte_enable,
		.mem_address,
		.mem_wdata,
		.mem_resp,
		.mem_rdata,
		.req_push,
		.req_data,
		.req_full,
		.rsp_pop,
		.rsp_data (rsp_head),
		.rsp_empty
	);

	strobe_fifo #(
		.payload_t (mem_bridge_pkg::line_req_t)
	) u_req_fifo (
		.clk,
		.rst_n,
		.push      (req_push),
		.push_data (req_data),
		.full      (req_full),
		.pop       (req_pop),
		.head      (req_head),
		.empty     (req_empty)
	);

	strobe_fifo #(
		.payload_t (mem_bridge_pkg::line_rsp_t)
	) u_rsp_fifo (
		.clk,
		.rst_n,
		.push      (rsp_push),
		.push_data (rsp_data),
		.full      (rsp_full),
		.pop       (rsp_pop),
		.head      (rsp_head),
		.empty     (rsp_empty)
	);

	line_store u_store (
		.clk,
		.rst_n,
		.req_pop,
		.req_head,
		.req_empty,
		.rsp_push,
		.rsp_data,
		.rsp_full
	);

endmodule : mem_bridge_top

/* tb/tb_mem_bridge.sv */
`timescale 1ns/1ps

module tb_mem_bridge;

	logic clk;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	mem_bridge_pkg::wmask_t mem_byte_enable;
	mem_bridge_pkg::word_t mem_address;
	mem_bridge_pkg::word_t mem_wdata;
	logic mem_resp;
	mem_bridge_pkg::word_t mem_rdata;

	// trace records
	logic [7:0] rec_op [$];
	mem_bridge_pkg::word_t rec_addr [$];
	mem_bridge_pkg::wmask_t rec_be [$];
	mem_bridge_pkg::word_t rec_wdata [$];
	mem_bridge_pkg::word_t rec_exp [$];
	int rec_count;
	logic trace_ok;

	int cycle_count;
	int cycle_limit;
	int pass_count;
	int fail_count;
	logic test_bad;
	mem_bridge_pkg::word_t got_rdata;
	int resp_pulses;
	int resp_total;
	int resp_base;

	mem_bridge_top u_dut (
		.clk,
		.rst_n,
		.mem_read,
		.mem_write,
		.mem_byte_enable,
		.mem_address,
		.mem_wdata,
		.mem_resp,
		.mem_rdata
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// run limit grows with the number of records
	initial begin
		cycle_count = 0;
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: mem_resp never arrived within %0d cycles", cycle_limit);
		$display("Test failures found");
		$finish;
	end

	// every mem_resp pulse, counted on the edge that ends it
	always @(posedge clk) begin
		if (mem_resp === 1'b1) begin
			resp_total++;
		end
	end

	task automatic load_trace();
		int fd;
		int n;
		logic bad_record;
		reg [8*96-1:0] skip_buf;
		logic [7:0] op;
		mem_bridge_pkg::word_t addr;
		mem_bridge_pkg::wmask_t be;
		mem_bridge_pkg::word_t wdata;
		mem_bridge_pkg::word_t exp_rdata;
		trace_ok = 1'b0;
		bad_record = 1'b0;
		rec_count = 0;
		fd = $fopen("tb/mem_bridge_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file tb/mem_bridge_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, " %c", op);
				if (n != 1) begin
					break;
				end
				if (op == "#") begin
					// rest of a comment line
					n = $fgets(skip_buf, fd);
				end else begin
					n = $fscanf(fd, "%h %h %h %h", addr, be, wdata, exp_rdata);
					if (n == 4 && (op == "R" || op == "W")) begin
						rec_op.push_back(op);
						rec_addr.push_back(addr);
						rec_be.push_back(be);
						rec_wdata.push_back(wdata);
						rec_exp.push_back(exp_rdata);
						rec_count++;
					end else begin
						$display("trace file holds a malformed record after record %0d",
							rec_count);
						bad_record = 1'b1;
						break;
					end
				end
			end
			$fclose(fd);
			if (rec_count == 0) begin
				$display("trace file holds no usable records");
			end else if (!bad_record) begin
				trace_ok = 1'b1;
			end
		end
	endtask

	task automatic drive_request(input int k);
		mem_read <= (rec_op[k] == "R");
		mem_write <= (rec_op[k] == "W");
		mem_byte_enable <= rec_be[k];
		mem_address <= rec_addr[k];
		mem_wdata <= rec_wdata[k];
	endtask

	task automatic drop_request();
		mem_read <= 1'b0;
		mem_write <= 1'b0;
	endtask

	// level is held until the first mem_resp
	task automatic wait_response(input int k);
		test_bad = 1'b0;
		do begin
			@(negedge clk);
		end while (mem_resp !== 1'b1);
		got_rdata = mem_rdata;
		assert (got_rdata == rec_exp[k]) else begin
			$display("MISMATCH at %0t: addr 0x%h expected 0x%h got 0x%h",
				$time, rec_addr[k], rec_exp[k], got_rdata);
			test_bad = 1'b1;
		end
	endtask

	// mem_resp pulses since the previous record was checked
	task automatic check_single_pulse(input int k);
		resp_pulses = resp_total - resp_base;
		resp_base = resp_total;
		assert (resp_pulses == 1) else begin
			$display("test %0d saw %0d mem_resp pulses where exactly one was due",
				k + 1, resp_pulses);
			test_bad = 1'b1;
		end
	endtask

	task automatic finish_test(input int k);
		if (test_bad) begin
			fail_count++;
			$display("test %0d %c addr 0x%h be %0d rdata 0x%h: FAILED",
				k + 1, rec_op[k], rec_addr[k], rec_be[k], got_rdata);
		end else begin
			pass_count++;
			$display("test %0d %c addr 0x%h be %0d rdata 0x%h: ok",
				k + 1, rec_op[k], rec_addr[k], rec_be[k], got_rdata);
		end
	endtask

	initial begin
		int gap;
		rst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_byte_enable = '0;
		mem_address = '0;
		mem_wdata = '0;
		cycle_limit = 0;
		pass_count = 0;
		fail_count = 0;
		test_bad = 1'b0;
		got_rdata = '0;
		resp_pulses = 0;
		resp_total = 0;
		resp_base = 0;
		void'($urandom(99846));

		load_trace();
		if (!trace_ok) begin
			fail_count++;
		end else begin
			cycle_limit = 200 + 20 * rec_count;
			repeat (5) @(posedge clk);
			rst_n <= 1'b1;

			gap = int'($urandom % 4);
			repeat (gap) @(posedge clk);
			@(posedge clk);
			drive_request(0);

			for (int k = 0; k < rec_count; k++) begin
				wait_response(k);
				gap = int'($urandom % 4);
				@(posedge clk);
				// zero gap keeps the level up with the next request
				if (k + 1 < rec_count && gap == 0) begin
					drive_request(k + 1);
				end else begin
					drop_request();
				end
				@(negedge clk);
				check_single_pulse(k);
				finish_test(k);
				if (k + 1 < rec_count && gap > 0) begin
					repeat (gap) @(posedge clk);
					drive_request(k + 1);
				end
			end

			// a duplicated request would answer a few cycles late
			repeat (8) @(negedge clk);
			assert (resp_total == rec_count) else begin
				$display("%0d mem_resp pulses arrived for %0d requests",
					resp_total, rec_count);
				fail_count++;
			end
		end

		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule : tb_mem_bridge

/* project.f */
+incdir+hdl
hdl/mem_bridge_pkg.sv
hdl/strobe_fifo.sv
hdl/word_lane_adapter.sv
hdl/line_store.sv
hdl/mem_bridge_top.sv
tb/tb_mem_bridge.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb_mem_bridge
LOG_FILE=sim.log

verilator --binary --timing --assert \
	-f project.f \
	--top-module tb_mem_bridge \
	-Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG_FILE"; then
	echo "simulation reported failures, see $LOG_FILE"
	exit 1
fi

echo "simulation clean, log in $LOG_FILE"
exit 0

/* tb/mem_bridge_trace.txt */
# op addr(hex) byte_enable(hex) wdata(hex) expected_rdata(hex)
# writes expect the word at their lane after the merge
R 0000 3 0000 0000
R 0012 3 0000 0000
R 03fe 1 0000 0000
R 7ff0 2 0000 0000
W 0100 3 a0b1 a0b1
W 0102 3 1c2d 1c2d
W 0104 3 3e4f 3e4f
W 0106 3 5061 5061
W 0108 3 7283 7283
W 010a 3 94a5 94a5
W 010c 3 b6c7 b6c7
W 010e 3 d8e9 d8e9
R 0100 3 0000 a0b1
R 0102 1 0000 1c2d
R 0104 2 0000 3e4f
R 0106 3 0000 5061
R 0108 3 0000 7283
R 010a 3 0000 94a5
R 010c 3 0000 b6c7
R 010e 3 0000 d8e9
R 0101 3 0000 a0b1
W 0200 3 1234 1234
W 0200 1 00ab 12ab
W 0200 2 cd99 cdab
R 0200 3 0000 cdab
W 020a 3 5566 5566
W 020b 2 ee00 ee66
R 020a 3 0000 ee66
R 020c 3 0000 0000
R 0208 3 0000 0000
W 0304 3 1111 1111
W 0704 3 2222 2222
R 0304 3 0000 2222
R 0704 3 0000 2222
W 0b06 3 3333 3333
R 0306 3 0000 3333
R 0304 3 0000 2222
R 0500 3 0000 a0b1
R 0d0e 3 0000 d8e9
